/* list.f */
memPkg.sv
memSeqCtrl.sv
memAddrGen.sv
memReadAssembler.sv
memWriteSerializer.sv
memCtrl.sv
tbMemModel.sv
tbMemCtrl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbMemCtrl -o simMemCtrl
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simMemCtrl)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

/* tbMemCtrl.sv */
module tbMemCtrl;

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore,
        opBoth
    } opKind_t;

    // stall bit 0 drops i_rdy, bit 1 raises i_ioBufferFull
    typedef struct packed {
        opKind_t    kind;
        logic [2:0] len;
        logic [1:0] stall;
        logic       reuse;
    } opEntry_t;

    localparam int numOps      = 21;
    localparam int resetCycles = 5;
    localparam int maxStalls   = 8;
    localparam int longestOp   = 14;
    localparam int opMargin    = 10;
    localparam int cycleLimit  = numOps * (longestOp + maxStalls + opMargin) + 4 * resetCycles;

    // reuse takes the data address of the entry before
    localparam opEntry_t opTable [numOps] = '{
        '{opFetch, 3'd4, 2'd0, 1'b0},
        '{opLoad,  3'd1, 2'd0, 1'b0},
        '{opLoad,  3'd2, 2'd0, 1'b0},
        '{opLoad,  3'd4, 2'd0, 1'b0},
        '{opStore, 3'd1, 2'd0, 1'b0},
        '{opLoad,  3'd1, 2'd0, 1'b1},
        '{opStore, 3'd2, 2'd0, 1'b0},
        '{opLoad,  3'd2, 2'd0, 1'b1},
        '{opStore, 3'd4, 2'd0, 1'b0},
        '{opLoad,  3'd4, 2'd0, 1'b1},
        '{opBoth,  3'd4, 2'd0, 1'b0},
        '{opBoth,  3'd1, 2'd0, 1'b0},
        '{opStore, 3'd4, 2'd1, 1'b0},
        '{opLoad,  3'd4, 2'd2, 1'b1},
        '{opStore, 3'd2, 2'd3, 1'b0},
        '{opLoad,  3'd2, 2'd1, 1'b1},
        '{opFetch, 3'd4, 2'd2, 1'b0},
        '{opBoth,  3'd2, 2'd3, 1'b0},
        '{opLoad,  3'd1, 2'd3, 1'b0},
        '{opStore, 3'd1, 2'd2, 1'b0},
        '{opLoad,  3'd4, 2'd1, 1'b1}
    };

    logic                         clk;
    logic                         rst;
    logic                         rdy;
    logic                         ioBufferFull;
    logic                         dcEn;
    memPkg::memReq_t              dcReq;
    logic                         infEn;
    logic [memPkg::addrWidth-1:0] infAddr;
    logic [memPkg::byteWidth-1:0] ramData;
    memPkg::ramPort_t             ram;
    logic                         dcDone;
    logic [memPkg::dataWidth-1:0] dcData;
    logic                         infDone;
    logic [memPkg::dataWidth-1:0] infInst;
    memPkg::memOwner_t            owner;

    logic [7:0]  refMem [256];
    logic [31:0] lcgState = 32'hf68b;
    logic [31:0] lastAddr = '0;
    int          errorCount = 0;
    int          failedTests = 0;
    int          cycleCount = 0;

    memCtrl u_dut (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_dcEn         (dcEn),
        .i_dcReq        (dcReq),
        .i_infEn        (infEn),
        .i_infAddr      (infAddr),
        .i_ramData      (ramData),
        .o_ram          (ram),
        .o_dcDone       (dcDone),
        .o_dcData       (dcData),
        .o_infDone      (infDone),
        .o_infInst      (infInst),
        .o_owner        (owner)
    );

    tbMemModel u_mem (
        .clk      (clk),
        .i_ram    (ram),
        .o_rdData (ramData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // power-up contents of the RAM model
    function automatic logic [7:0] fillByte(input int a);
        return 8'(a * 29) ^ 8'h5a;
    endfunction

    // little-endian and zero above len bytes
    function automatic logic [31:0] refWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*8 +: 8] = refMem[8'(addr + 32'(k))];
        end
        return w;
    endfunction

    function automatic string kindName(input opKind_t kind);
        case (kind)
            opFetch: return "fetch";
            opLoad:  return "load";
            opStore: return "store";
            default: return "data+fetch";
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR time %0t %s expected %h got %h", $time, name, exp, got);
            errorCount++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond) else begin
            $display("time %0t: %s", $time, what);
            errorCount++;
        end
    endtask

    task automatic finishTest(input int idx, input string name, input int errBefore);
        if (errorCount == errBefore) begin
            $display("test %0d %s: ok", idx, name);
        end else begin
            $display("test %0d %s: %0d errors", idx, name, errorCount - errBefore);
            failedTests++;
        end
    endtask

    task automatic runOp(input opEntry_t op);
        memPkg::memReq_t req;
        logic [31:0]     fetchAddr;
        logic [31:0]     expData;
        logic [31:0]     expInst;
        logic [31:0]     r;
        logic            dcPending;
        logic            infPending;
        logic            dcAccepted;
        logic            infAccepted;
        logic            idleCycle;
        logic            active;
        logic            stall;
        int              len;
        int              dcExpCount;
        int              dcCount;
        int              infCount;
        int              stallsLeft;
        int              logStart;
        int              expWrites;

        len         = int'(op.len);
        req.addr    = op.reuse ? lastAddr : nextRandom() % 32'd252;
        req.data    = nextRandom();
        req.len     = op.len;
        req.store   = (op.kind == opStore);
        fetchAddr   = nextRandom() % 32'd252;
        expData     = refWord(req.addr, len);
        expInst     = refWord(fetchAddr, 4);
        dcPending   = (op.kind != opFetch);
        infPending  = (op.kind == opFetch) || (op.kind == opBoth);
        dcAccepted  = 1'b0;
        infAccepted = 1'b0;
        dcCount     = 0;
        infCount    = 0;
        dcExpCount  = req.store ? len : len + 1;
        expWrites   = req.store ? len : 0;
        stallsLeft  = maxStalls;
        logStart    = u_mem.logCount;
        if (dcPending) begin
            lastAddr = req.addr;
        end

        dcEn    <= dcPending;
        dcReq   <= req;
        infEn   <= infPending;
        infAddr <= fetchAddr;

        while (dcPending || infPending) begin
            @(posedge clk);
            active    = rdy && !ioBufferFull;
            idleCycle = !dcAccepted && !infAccepted;
            checkTrue(!(ram.wrEn && !active), "RAM write during a stalled cycle");
            checkTrue(!((dcDone || infDone) && !active), "done pulse during a stalled cycle");
            if (idleCycle) begin
                checkValue("o_owner", 32'(owner), 32'(memPkg::ownerIdle));
            end
            if (dcAccepted) begin
                if (active) dcCount++;
                checkValue("o_owner", 32'(owner), 32'(memPkg::ownerData));
            end
            if (infAccepted) begin
                if (active) infCount++;
                checkValue("o_owner", 32'(owner), 32'(memPkg::ownerFetch));
            end
            if (dcDone) begin
                checkTrue(dcAccepted, "o_dcDone without an accepted data request");
                checkValue("dcActiveCycles", dcCount, dcExpCount);
                if (req.store) begin
                    // done comes with the last write
                    checkValue("o_ram.wrEn", 32'(ram.wrEn), 32'd1);
                end else begin
                    checkValue("o_dcData", dcData, expData);
                end
                dcPending  = 1'b0;
                dcAccepted = 1'b0;
                dcEn      <= 1'b0;
            end
            if (infDone) begin
                checkTrue(infAccepted, "o_infDone without an accepted fetch");
                checkTrue(!dcPending, "fetch finished before the data access");
                checkValue("infActiveCycles", infCount, 5);
                checkValue("o_infInst", infInst, expInst);
                infPending  = 1'b0;
                infAccepted = 1'b0;
                infEn      <= 1'b0;
            end
            // an active idle cycle with a request pending ends in acceptance
            if (idleCycle && active) begin
                if (dcPending) begin
                    dcAccepted = 1'b1;
                    dcCount    = 0;
                end else if (infPending) begin
                    infAccepted = 1'b1;
                    infCount    = 0;
                end
            end
            r     = nextRandom();
            stall = (op.stall != 2'b00) && (stallsLeft > 0) && (r[17:16] == 2'b00);
            if (stall) stallsLeft--;
            rdy          <= !(stall && op.stall[0]);
            ioBufferFull <= stall && op.stall[1];
        end

        rdy          <= 1'b1;
        ioBufferFull <= 1'b0;
        @(posedge clk);
        checkValue("o_owner", 32'(owner), 32'(memPkg::ownerIdle));
        checkValue("writeCount", u_mem.logCount - logStart, expWrites);
        for (int k = 0; k < expWrites; k++) begin
            checkValue("writeAddr", u_mem.logAddr[logStart + k], req.addr + 32'(k));
            checkValue("writeData", 32'(u_mem.logData[logStart + k]), 32'(req.data[k*8 +: 8]));
            refMem[8'(req.addr + 32'(k))] = req.data[k*8 +: 8];
        end
    endtask

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: operations did not finish within %0d cycles", cycleLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int errBefore;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        dcEn         = 1'b0;
        dcReq        = '0;
        infEn        = 1'b0;
        infAddr      = '0;
        for (int i = 0; i < 256; i++) begin
            refMem[i] = fillByte(i);
        end
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        errBefore = errorCount;
        checkValue("o_dcDone", 32'(dcDone), 32'd0);
        checkValue("o_infDone", 32'(infDone), 32'd0);
        checkValue("o_ram.wrEn", 32'(ram.wrEn), 32'd0);
        checkValue("o_owner", 32'(owner), 32'(memPkg::ownerIdle));
        checkValue("o_dcData", dcData, 32'd0);
        checkValue("o_infInst", infInst, 32'd0);
        finishTest(0, "reset", errBefore);
        for (int i = 0; i < numOps; i++) begin
            errBefore = errorCount;
            runOp(opTable[i]);
            finishTest(i + 1, $sformatf("%s len %0d", kindName(opTable[i].kind),
                       opTable[i].len), errBefore);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d", numOps + 1,
                 numOps + 1 - failedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tbMemModel.sv */
module tbMemModel #(
    parameter int logDepth = 64
) (
    input  logic                         clk,
    input  memPkg::ramPort_t             i_ram,
    output logic [memPkg::byteWidth-1:0] o_rdData
);

    localparam int memDepth = 256;

    logic [memPkg::byteWidth-1:0] mem [memDepth];

    // every write in arrival order, read by the testbench
    logic [memPkg::addrWidth-1:0] logAddr [logDepth];
    logic [memPkg::byteWidth-1:0] logData [logDepth];
    int                           logCount;

    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = 8'(i * 29) ^ 8'h5a;
        end
        logCount = 0;
        o_rdData = '0;
    end

    // read data shows up one cycle after its address
    always @(posedge clk) begin
        o_rdData <= mem[i_ram.addr[7:0]];
        if (i_ram.wrEn) begin
            mem[i_ram.addr[7:0]] <= i_ram.wrData;
            if (logCount < logDepth) begin
                logAddr[logCount] <= i_ram.addr;
                logData[logCount] <= i_ram.wrData;
            end
            logCount <= logCount + 1;
        end
    end

endmodule

/* memCtrl.sv */
module memCtrl #(
    parameter int unsigned addrStep = memPkg::defaultAddrStep
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_rdy,
    input  logic                          i_ioBufferFull,

    input  logic                          i_dcEn,
    input  memPkg::memReq_t               i_dcReq,
    input  logic                          i_infEn,
    input  logic [memPkg::addrWidth-1:0]  i_infAddr,

    input  logic [memPkg::byteWidth-1:0]  i_ramData,
    output memPkg::ramPort_t              o_ram,

    output logic                          o_dcDone,
    output logic [memPkg::dataWidth-1:0]  o_dcData,
    output logic                          o_infDone,
    output logic [memPkg::dataWidth-1:0]  o_infInst,
    output memPkg::memOwner_t             o_owner
);

    logic                         loadAddr;
    logic                         selData;
    logic [memPkg::lenWidth-1:0]  byteIdx;
    logic                         issue;
    logic                         write;
    logic                         clear;
    logic                         finish;
    memPkg::memOwner_t            owner;
    logic [memPkg::addrWidth-1:0] addr;
    logic [memPkg::dataWidth-1:0] word;
    logic [memPkg::lenWidth-1:0]  asmLen;

    memSeqCtrl u_seq (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcReq.store),
        .i_dcLen        (i_dcReq.len),
        .i_infEn        (i_infEn),
        .o_loadAddr     (loadAddr),
        .o_selData      (selData),
        .o_byteIdx      (byteIdx),
        .o_issue        (issue),
        .o_write        (write),
        .o_clear        (clear),
        .o_finish       (finish),
        .o_dcDone       (o_dcDone),
        .o_infDone      (o_infDone),
        .o_owner        (owner)
    );

    memAddrGen #(
        .addrStep (addrStep)
    ) u_addrGen (
        .clk       (clk),
        .rst       (rst),
        .i_load    (loadAddr),
        .i_selData (selData),
        .i_dcAddr  (i_dcReq.addr),
        .i_infAddr (i_infAddr),
        .i_byteIdx (byteIdx),
        .o_addr    (addr)
    );

    // fetch always reads a full word
    assign asmLen = (owner == memPkg::ownerFetch) ? memPkg::fetchLen : i_dcReq.len;

    memReadAssembler u_readAsm (
        .clk       (clk),
        .rst       (rst),
        .i_clear   (clear),
        .i_issue   (issue),
        .i_finish  (finish),
        .i_len     (asmLen),
        .i_ramData (i_ramData),
        .o_word    (word)
    );

    memWriteSerializer u_writeSer (
        .clk         (clk),
        .rst         (rst),
        .i_load      (loadAddr),
        .i_storeData (i_dcReq.data),
        .i_byteIdx   (byteIdx),
        .i_write     (write),
        .i_addr      (addr),
        .o_ram       (o_ram)
    );

    assign o_dcData  = word;
    assign o_infInst = word;
    assign o_owner   = owner;

endmodule

/* memWriteSerializer.sv */
module memWriteSerializer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_load,
    input  logic [memPkg::dataWidth-1:0]  i_storeData,
    input  logic [memPkg::lenWidth-1:0]   i_byteIdx,
    input  logic                          i_write,
    input  logic [memPkg::addrWidth-1:0]  i_addr,
    output memPkg::ramPort_t              o_ram
);

    logic [memPkg::dataWidth-1:0] storeData;
    logic [memPkg::byteWidth-1:0] selByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeData <= '0;
        end else if (i_load) begin
            storeData <= i_storeData;
        end
    end

    // low byte goes out first
    always_comb begin
        case (i_byteIdx)
            3'd0:    selByte = storeData[7:0];
            3'd1:    selByte = storeData[15:8];
            3'd2:    selByte = storeData[23:16];
            3'd3:    selByte = storeData[31:24];
            default: selByte = '0;
        endcase
    end

    always_comb begin
        o_ram.addr   = i_addr;
        o_ram.wrData = selByte;
        o_ram.wrEn   = i_write;
    end

endmodule

/* memReadAssembler.sv */
module memReadAssembler (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_clear,
    input  logic                          i_issue,
    input  logic                          i_finish,
    input  logic [memPkg::lenWidth-1:0]   i_len,
    input  logic [memPkg::byteWidth-1:0]  i_ramData,
    output logic [memPkg::dataWidth-1:0]  o_word
);

    localparam int laneCount = memPkg::dataWidth / memPkg::byteWidth;

    logic                         issuedQ;
    logic [1:0]                   laneIdx;
    logic [memPkg::dataWidth-1:0] laneWord;
    logic                         capture;

    // byte on i_ramData belongs to the address of the previous active cycle
    assign capture = issuedQ && i_issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            issuedQ <= 1'b0;
            laneIdx <= '0;
        end else if (i_clear) begin
            issuedQ <= 1'b0;
            laneIdx <= '0;
        end else if (i_issue || i_finish) begin
            issuedQ <= i_issue;
            if (capture) begin
                laneIdx <= laneIdx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            laneWord[laneIdx * memPkg::byteWidth +: memPkg::byteWidth] <= i_ramData;
        end
    end

    // last byte comes live from the RAM, lanes above the length read zero
    always_comb begin
        int lastLane;
        lastLane = int'(i_len) - 1;
        o_word   = '0;
        if (i_finish) begin
            for (int i = 0; i < laneCount; i++) begin
                if (i < lastLane) begin
                    o_word[i*memPkg::byteWidth +: memPkg::byteWidth] =
                        laneWord[i*memPkg::byteWidth +: memPkg::byteWidth];
                end else if (i == lastLane) begin
                    o_word[i*memPkg::byteWidth +: memPkg::byteWidth] = i_ramData;
                end
            end
        end
    end

endmodule

/* memAddrGen.sv */
module memAddrGen #(
    parameter int unsigned addrStep = memPkg::defaultAddrStep
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_load,
    input  logic                          i_selData,
    input  logic [memPkg::addrWidth-1:0]  i_dcAddr,
    input  logic [memPkg::addrWidth-1:0]  i_infAddr,
    input  logic [memPkg::lenWidth-1:0]   i_byteIdx,
    output logic [memPkg::addrWidth-1:0]  o_addr
);

    logic [memPkg::addrWidth-1:0] baseAddr;
    logic [memPkg::addrWidth-1:0] idxWide;
    logic [memPkg::addrWidth-1:0] offset;

    // base of the running access, held between accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr <= '0;
        end else if (i_load) begin
            baseAddr <= i_selData ? i_dcAddr : i_infAddr;
        end
    end

    assign idxWide = {{(memPkg::addrWidth - memPkg::lenWidth){1'b0}}, i_byteIdx};
    assign offset  = idxWide * addrStep;
    assign o_addr  = baseAddr + offset;

endmodule

/* memSeqCtrl.sv */
module memSeqCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_rdy,
    input  logic                         i_ioBufferFull,
    input  logic                         i_dcEn,
    input  logic                         i_dcStore,
    input  logic [memPkg::lenWidth-1:0]  i_dcLen,
    input  logic                         i_infEn,
    output logic                         o_loadAddr,
    output logic                         o_selData,
    output logic [memPkg::lenWidth-1:0]  o_byteIdx,
    output logic                         o_issue,
    output logic                         o_write,
    output logic                         o_clear,
    output logic                         o_finish,
    output logic                         o_dcDone,
    output logic                         o_infDone,
    output memPkg::memOwner_t            o_owner
);

    localparam logic [memPkg::lenWidth-1:0] oneLen = 1;

    memPkg::memOwner_t           owner;
    logic                        isStore;
    logic [memPkg::lenWidth-1:0] curLen;
    logic [memPkg::lenWidth-1:0] byteIdx;

    logic active;
    logic busy;
    logic accept;
    logic lastStore;
    logic lastLoad;
    logic lastStep;
    logic done;

    // the only place where the stall levels are looked at
    assign active = i_rdy && !i_ioBufferFull;
    assign busy   = (owner != memPkg::ownerIdle);
    assign accept = active && !busy && (i_dcEn || i_infEn);

    // stores finish on the last write, loads one cycle after the last address
    assign lastStore = isStore && (byteIdx == curLen - oneLen);
    assign lastLoad  = !isStore && (byteIdx == curLen);
    assign lastStep  = busy && (lastStore || lastLoad);
    assign done      = active && lastStep;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner   <= memPkg::ownerIdle;
            isStore <= 1'b0;
            curLen  <= '0;
            byteIdx <= '0;
        end else if (active) begin
            if (accept) begin
                byteIdx <= '0;
                // data side wins a tie
                if (i_dcEn) begin
                    owner   <= memPkg::ownerData;
                    isStore <= i_dcStore;
                    curLen  <= i_dcLen;
                end else begin
                    owner   <= memPkg::ownerFetch;
                    isStore <= 1'b0;
                    curLen  <= memPkg::fetchLen;
                end
            end else if (lastStep) begin
                owner   <= memPkg::ownerIdle;
                byteIdx <= '0;
            end else if (busy) begin
                byteIdx <= byteIdx + oneLen;
            end
        end
    end

    assign o_loadAddr = accept;
    assign o_clear    = accept;
    assign o_selData  = i_dcEn;

    // while stalled in a read, keep the address that was issued last,
    // so the RAM returns that byte again when activity resumes
    always_comb begin
        if (!active && busy && !isStore && (byteIdx != '0)) begin
            o_byteIdx = byteIdx - oneLen;
        end else begin
            o_byteIdx = byteIdx;
        end
    end

    assign o_issue  = active && busy && !isStore && !lastLoad;
    assign o_finish = active && busy && lastLoad;
    assign o_write  = active && busy && isStore;

    assign o_dcDone  = done && (owner == memPkg::ownerData);
    assign o_infDone = done && (owner == memPkg::ownerFetch);
    assign o_owner   = owner;

endmodule

/* memPkg.sv */
package memPkg;

    // bus widths
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int byteWidth = 8;

    // byte count of one access, legal values 1, 2 and 4
    localparam int lenWidth = 3;

    localparam logic [lenWidth-1:0] fetchLen = 3'd4;

    // address increment per byte
    localparam int unsigned defaultAddrStep = 1;

    // current owner of the RAM port
    typedef enum logic [1:0] {
        ownerIdle,
        ownerData,
        ownerFetch
    } memOwner_t;

    // one data request, fetch uses it with len 4 and store clear
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic [lenWidth-1:0]  len;
        logic                 store;
    } memReq_t;

    // what the controller drives to the byte RAM
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic [byteWidth-1:0] wrData;
        logic                 wrEn;
    } ramPort_t;

endpackage
